//--- list.f
hw/cpu_pkg.sv
hw/mem_bus_if.sv
hw/boot_memory.sv
hw/program_counter.sv
hw/cpu_sequencer.sv
hw/acc_alu.sv
hw/cpu_top.sv
bench/cpu_checker.sv
bench/tb_cpu_top.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only -Wall --timing
TOP        = tb_cpu_top
RTL_TOP    = cpu_top
FILELIST   = list.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/tb_cpu_top.sv
// testbench for the accumulator core: loads programs over the host port,
// runs them and reads the results back
`timescale 1ns/10ps

module tb_cpu_top
  import cpu_pkg::*;
();

  localparam int         timeout_cycles = 200;
  localparam logic [1:0] k_load         = 2'd0;
  localparam logic [1:0] k_run          = 2'd1;
  localparam logic [1:0] k_read         = 2'd2;
  localparam logic [1:0] k_run_poke     = 2'd3; // run with a host write while busy
  localparam logic [15:0] poke_word     = 16'hbeef;

  typedef struct packed {
    logic [1:0]  kind;
    logic [7:0]  addr;
    logic [15:0] data;
    logic [15:0] expected;
  } entry_t;

  logic        CLK;
  logic        rst_n;
  logic        start;
  logic [7:0]  start_addr;
  logic        host_wr;
  logic        host_rd;
  logic [7:0]  host_addr;
  logic [15:0] host_wdata;
  logic [15:0] host_rdata;
  logic        host_rvalid;
  logic        done;
  logic        busy;
  logic [15:0] acc;
  logic [15:0] exp_value;
  logic        timed_out;
  int          test_id;
  int          pass_count;
  int          fail_count;
  logic [31:0] lfsr_state;
  entry_t      tests [64];
  int          n_tests;

  always #10 CLK = ~CLK;

  cpu_top #(.addr_bits(8)) i_cpu_top (
    .CLK (CLK), .rst_n (rst_n), .start (start), .start_addr (start_addr),
    .host_wr (host_wr), .host_rd (host_rd), .host_addr (host_addr),
    .host_wdata (host_wdata), .host_rdata (host_rdata), .host_rvalid (host_rvalid),
    .done (done), .busy (busy), .acc (acc)
  );

  cpu_checker i_cpu_checker (
    .CLK (CLK), .rst_n (rst_n), .start (start), .done (done), .busy (busy),
    .host_rd (host_rd), .host_rvalid (host_rvalid), .host_rdata (host_rdata), .acc (acc),
    .exp_value (exp_value), .timed_out (timed_out), .test_id (test_id),
    .pass_count (pass_count), .fail_count (fail_count)
  );

  task automatic tick;
    @(posedge CLK);
    #1;
  endtask

  // galois LFSR, one step per bit taken
  function automatic logic [15:0] rand_word();
    logic [15:0] w;
    w = '0;
    for (int i = 0; i < 16; i++)
    begin
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
      w = {w[14:0], lfsr_state[0]};
    end
    return w;
  endfunction

  function automatic logic [15:0] mem_op(input opcode_e op, input logic [7:0] a);
    return {op, 4'h0, a};
  endfunction

  function automatic logic [15:0] imm_op(input opcode_e op, input logic [11:0] v);
    return {op, v};
  endfunction

  function void add_entry(input logic [1:0] k, input logic [7:0] a, input logic [15:0] d,
                          input logic [15:0] e);
    tests[n_tests] = '{kind: k, addr: a, data: d, expected: e};
    n_tests++;
  endfunction

  task automatic build_table;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] c;
    logic [15:0] res [4];
    opcode_e     ops [4];
    logic [7:0]  pa;
    add_entry(k_run, 8'h00, 16'h0, 16'h000f); // boot image sums 3 + 5 + 7
    add_entry(k_read, 8'h13, 16'h0, 16'h000f);
    a = rand_word();
    b = rand_word();
    ops = '{ADD, SUB, AND, XOR};
    res = '{a + b, a - b, a & b, a ^ b};
    add_entry(k_load, 8'h30, a, 16'h0);
    add_entry(k_load, 8'h31, b, 16'h0);
    for (int i = 0; i < 4; i++)
    begin
      pa = 8'(8'h40 + 3 * i);
      add_entry(k_load, pa, mem_op(LD, 8'h30), 16'h0);
      add_entry(k_load, pa + 8'd1, mem_op(ops[i], 8'h31), 16'h0);
      add_entry(k_load, pa + 8'd2, mem_op(ST, 8'(8'h32 + i)), 16'h0);
    end
    add_entry(k_load, 8'h4c, imm_op(HALT, 12'h0), 16'h0);
    add_entry(k_run, 8'h40, 16'h0, res[3]);
    for (int i = 0; i < 4; i++)
    begin
      add_entry(k_read, 8'(8'h32 + i), 16'h0, res[i]);
    end
    // each wrong branch leaves its own mark in acc
    add_entry(k_load, 8'h60, imm_op(LDI, 12'h000), 16'h0);
    add_entry(k_load, 8'h61, imm_op(JZ, 12'h063), 16'h0);
    add_entry(k_load, 8'h62, imm_op(LDI, 12'h7ff), 16'h0);
    add_entry(k_load, 8'h63, mem_op(ADD, 8'h70), 16'h0);
    add_entry(k_load, 8'h64, imm_op(JZ, 12'h066), 16'h0);
    add_entry(k_load, 8'h65, mem_op(ADD, 8'h71), 16'h0);
    add_entry(k_load, 8'h66, imm_op(JMP, 12'h068), 16'h0);
    add_entry(k_load, 8'h67, mem_op(ADD, 8'h72), 16'h0);
    add_entry(k_load, 8'h68, imm_op(HALT, 12'h0), 16'h0);
    add_entry(k_load, 8'h70, 16'h0100, 16'h0);
    add_entry(k_load, 8'h71, 16'h0010, 16'h0);
    add_entry(k_load, 8'h72, 16'h1000, 16'h0);
    add_entry(k_run, 8'h60, 16'h0, 16'h0110);
    c = rand_word();
    add_entry(k_load, 8'h80, c, 16'h0);
    add_entry(k_read, 8'h80, 16'h0, c);
    add_entry(k_run_poke, 8'h00, 16'h0080, 16'h000f);
    add_entry(k_read, 8'h80, 16'h0, c); // the write during the run must be dropped
    add_entry(k_load, 8'h90, imm_op(LDI, 12'h00a), 16'h0);
    add_entry(k_load, 8'h91, 16'ha123, 16'h0);
    add_entry(k_load, 8'h92, mem_op(ADD, 8'h70), 16'h0);
    add_entry(k_load, 8'h93, 16'hc0ff, 16'h0);
    add_entry(k_load, 8'h94, imm_op(NOP, 12'h0), 16'h0);
    add_entry(k_load, 8'h95, imm_op(HALT, 12'h0), 16'h0);
    add_entry(k_run, 8'h90, 16'h0, 16'h010a);
  endtask

  // waits for done or host_rvalid, then lets the checker sample it at the next edge
  task automatic wait_strobe(input bit want_done);
    int cycles;
    cycles = 0;
    while ((want_done ? done : host_rvalid) !== 1'b1 && cycles < timeout_cycles)
    begin
      tick;
      cycles++;
    end
    if (cycles >= timeout_cycles)
    begin
      timed_out = 1'b1;
    end
    tick;
    timed_out = 1'b0;
  endtask

  task automatic apply_entry(input entry_t e, input int idx);
    test_id   = idx;
    exp_value = e.expected;
    case (e.kind)
      k_load:
      begin
        host_wr    = 1'b1;
        host_addr  = e.addr;
        host_wdata = e.data;
        tick;
        host_wr    = 1'b0;
      end
      k_read:
      begin
        host_rd   = 1'b1;
        host_addr = e.addr;
        tick;
        host_rd   = 1'b0;
        wait_strobe(1'b0);
      end
      default:
      begin
        start      = 1'b1;
        start_addr = e.addr;
        tick;
        start      = 1'b0;
        if (e.kind == k_run_poke)
        begin
          host_wr    = 1'b1;
          host_addr  = e.data[7:0];
          host_wdata = poke_word;
          tick;
          host_wr    = 1'b0;
        end
        wait_strobe(1'b1);
      end
    endcase
  endtask

  initial
  begin
    CLK        = 1'b0;
    rst_n      = 1'b0;
    start      = 1'b0;
    start_addr = '0;
    host_wr    = 1'b0;
    host_rd    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    exp_value  = '0;
    timed_out  = 1'b0;
    test_id    = 0;
    n_tests    = 0;
    lfsr_state = 32'hea8bd8e8;
    build_table();
    repeat (5) @(posedge CLK);
    #1;
    rst_n = 1'b1;
    tick;
    for (int i = 0; i < n_tests; i++)
    begin
      apply_entry(tests[i], i);
    end
    repeat (2) tick;
    $display("checks: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0 && pass_count > 0)
    begin
      $display("TB PASSED");
    end
    else
    begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- bench/cpu_checker.sv
// result checker: watches the DUT and compares acc at done and host_rdata at host_rvalid
`timescale 1ns/10ps

module cpu_checker (
  input  logic        CLK,
  input  logic        rst_n,
  input  logic        start,
  input  logic        done,
  input  logic        busy,
  input  logic        host_rd,
  input  logic        host_rvalid,
  input  logic [15:0] host_rdata,
  input  logic [15:0] acc,
  input  logic [15:0] exp_value,
  input  logic        timed_out,
  input  int          test_id,
  output int          pass_count,
  output int          fail_count
);

  logic rd_pending; // a host read was accepted at the previous edge
  logic running;    // a run was started and its done has not been seen yet
  logic busy_exp;

  assign busy_exp = running && !done; // the core is back in HALTED on the done cycle

  task automatic compare_word(input string name, input logic [15:0] got);
    if (got !== exp_value)
    begin
      $display("Fail test %0d: %s = 0x%04h, expected 0x%04h", test_id, name, got, exp_value);
      fail_count++;
    end
    else
    begin
      $display("test %0d ok: %s = 0x%04h", test_id, name, got);
      pass_count++;
    end
  endtask

  always @(posedge CLK)
  begin
    if (!rst_n)
    begin
      rd_pending <= 1'b0;
      running    <= 1'b0;
      pass_count = 0;
      fail_count = 0;
    end
    else
    begin
      if (busy !== busy_exp)
      begin
        $display("Fail test %0d: busy = 0x%h, expected 0x%h", test_id, busy, busy_exp);
        fail_count++;
      end
      if (host_rvalid !== rd_pending)
      begin
        $display("Fail test %0d: host_rvalid = 0x%h, expected 0x%h", test_id, host_rvalid,
                 rd_pending);
        fail_count++;
      end
      else if (host_rvalid)
      begin
        compare_word("host_rdata", host_rdata);
      end
      if (done && !running)
      begin
        $display("Fail test %0d: done = 0x%h, expected 0x0", test_id, done);
        fail_count++;
      end
      else if (done)
      begin
        compare_word("acc", acc);
      end
      if (timed_out)
      begin
        $display("test %0d: the DUT gave no response within the timeout", test_id);
        fail_count++;
      end
      rd_pending <= host_rd && !busy_exp;
      if (start && !busy_exp)
      begin
        running <= 1'b1;
      end
      else if (done)
      begin
        running <= 1'b0;
      end
    end
  end

endmodule

//--- hw/cpu_top.sv
// cpu top: accumulator core with its boot memory and host port
// the host may use the memory while the core is idle or halted
`timescale 1ns/10ps

module cpu_top
  import cpu_pkg::*;
#(
  parameter int addr_bits = 8
)
(
  input  logic                 CLK,
  input  logic                 rst_n,
  input  logic                 start,
  input  logic [addr_bits-1:0] start_addr,
  input  logic                 host_wr,
  input  logic                 host_rd,
  input  logic [addr_bits-1:0] host_addr,
  input  logic [data_w-1:0]    host_wdata,
  output logic [data_w-1:0]    host_rdata,
  output logic                 host_rvalid,
  output logic                 done,
  output logic                 busy,
  output logic [data_w-1:0]    acc
);

  logic [addr_bits-1:0]  pc;
  logic                  pc_load;
  logic [addr_bits-1:0]  pc_load_value;
  logic                  pc_step;
  alu_op_e               alu_op;
  logic                  alu_en;
  logic [addr_w_max-1:0] imm;
  logic [data_w-1:0]     operand;
  logic                  zero;

  mem_bus_if #(.addr_bits(addr_bits)) i_mem_bus ();

  boot_memory #(.addr_bits(addr_bits)) i_boot_memory (
    .CLK (CLK),
    .mem (i_mem_bus.memory)
  );

  program_counter #(.addr_bits(addr_bits)) i_program_counter (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .load       (pc_load),
    .load_value (pc_load_value),
    .step       (pc_step),
    .pc         (pc)
  );

  cpu_sequencer #(.addr_bits(addr_bits)) i_cpu_sequencer (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .start         (start),
    .start_addr    (start_addr),
    .host_wr       (host_wr),
    .host_rd       (host_rd),
    .host_addr     (host_addr),
    .host_wdata    (host_wdata),
    .host_rvalid   (host_rvalid),
    .host_rdata    (host_rdata),
    .done          (done),
    .busy          (busy),
    .mem           (i_mem_bus.sequencer),
    .pc            (pc),
    .pc_load       (pc_load),
    .pc_load_value (pc_load_value),
    .pc_step       (pc_step),
    .alu_op        (alu_op),
    .alu_en        (alu_en),
    .imm           (imm),
    .operand       (operand),
    .acc           (acc),
    .zero          (zero)
  );

  acc_alu i_acc_alu (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .op      (alu_op),
    .en      (alu_en),
    .imm     (imm),
    .operand (operand),
    .acc     (acc),
    .zero    (zero)
  );

endmodule

//--- hw/acc_alu.sv
// accumulator with its ALU
// all results wrap modulo 2^16
`timescale 1ns/10ps

module acc_alu
  import cpu_pkg::*;
(
  input  logic                  CLK,
  input  logic                  rst_n,
  input  alu_op_e               op,
  input  logic                  en,
  input  logic [addr_w_max-1:0] imm,
  input  logic [data_w-1:0]     operand,
  output logic [data_w-1:0]     acc,
  output logic                  zero
);

  logic [data_w-1:0] acc_q;
  logic [data_w-1:0] result;

  always_comb
  begin
    case (op)
      ALU_PASS_IMM: result = data_w'(imm); // immediate is zero-extended
      ALU_PASS_MEM: result = operand;
      ALU_ADD:      result = acc_q + operand;
      ALU_SUB:      result = acc_q - operand;
      ALU_AND:      result = acc_q & operand;
      ALU_XOR:      result = acc_q ^ operand;
      default:      result = acc_q;
    endcase
  end

  always_ff @(posedge CLK or negedge rst_n)
  begin
    if (!rst_n)
    begin
      acc_q <= '0;
    end
    else if (en)
    begin
      acc_q <= result;
    end
  end

  // JZ looks at the accumulator as it stands before the jump executes
  assign zero = (acc_q == '0);
  assign acc  = acc_q;

endmodule

//--- hw/cpu_sequencer.sv
// cpu sequencer: fetch/decode/execute FSM with the instruction register,
// also gives the host the memory port while the core is idle or halted
`timescale 1ns/10ps

module cpu_sequencer
  import cpu_pkg::*;
#(
  parameter int addr_bits = 8
)
(
  input  logic                  CLK,
  input  logic                  rst_n,
  input  logic                  start,
  input  logic [addr_bits-1:0]  start_addr,
  input  logic                  host_wr,
  input  logic                  host_rd,
  input  logic [addr_bits-1:0]  host_addr,
  input  logic [data_w-1:0]     host_wdata,
  output logic                  host_rvalid,
  output logic [data_w-1:0]     host_rdata,
  output logic                  done,
  output logic                  busy,
  mem_bus_if.sequencer          mem,
  input  logic [addr_bits-1:0]  pc,
  output logic                  pc_load,
  output logic [addr_bits-1:0]  pc_load_value,
  output logic                  pc_step,
  output alu_op_e               alu_op,
  output logic                  alu_en,
  output logic [addr_w_max-1:0] imm,
  output logic [data_w-1:0]     operand,
  input  logic [data_w-1:0]     acc,
  input  logic                  zero
);

  seq_state_e           state;
  seq_state_e           next_state;
  instr_t               ir;
  instr_t               fetched;
  logic                 host_slot;
  logic [addr_bits-1:0] operand_addr;
  logic [addr_bits-1:0] jump_target;

  assign fetched      = mem.rdata; // instruction word as it arrives in DECODE
  assign host_slot    = (state == IDLE) || (state == HALTED);
  assign busy         = !host_slot;
  assign operand_addr = addr_bits'(ir.mem_v.addr);
  assign jump_target  = addr_bits'(ir.imm_v.imm);
  assign imm          = ir.imm_v.imm;
  assign operand      = mem.rdata; // operand word is on the bus during EXEC
  assign host_rdata   = mem.rdata;

  always_ff @(posedge CLK or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state       <= IDLE;
      done        <= 1'b0;
      host_rvalid <= 1'b0;
    end
    else
    begin
      state       <= next_state;
      done        <= (state == EXEC) && (ir.imm_v.opcode == HALT);
      host_rvalid <= host_rd && host_slot; // strobes while busy are dropped
    end
  end

  always_ff @(posedge CLK)
  begin
    if (state == DECODE)
    begin
      ir <= fetched;
    end
  end

  always_comb
  begin
    next_state    = state;
    mem.addr      = pc;
    mem.wdata     = acc;
    mem.wr        = 1'b0;
    pc_load       = 1'b0;
    pc_load_value = jump_target;
    pc_step       = 1'b0;
    alu_op        = ALU_HOLD;
    alu_en        = 1'b0;

    case (state)
      IDLE, HALTED:
      begin
        // the bus is free in this cycle even when start arrives with a host strobe
        if (host_wr || host_rd)
        begin
          mem.addr = host_addr;
        end
        if (host_wr)
        begin
          mem.wdata = host_wdata;
          mem.wr    = 1'b1;
        end
        if (start)
        begin
          pc_load       = 1'b1;
          pc_load_value = start_addr;
          next_state    = FETCH;
        end
      end
      FETCH:
      begin
        pc_step    = 1'b1;
        next_state = DECODE;
      end
      DECODE:
      begin
        case (fetched.mem_v.opcode)
          LD, ADD, SUB, AND, XOR: next_state = OPREAD;
          default:                next_state = EXEC; // ST needs no read
        endcase
      end
      OPREAD:
      begin
        mem.addr   = operand_addr;
        next_state = EXEC;
      end
      EXEC:
      begin
        next_state = FETCH;
        case (ir.imm_v.opcode)
          LDI:
          begin
            alu_op = ALU_PASS_IMM;
            alu_en = 1'b1;
          end
          LD:
          begin
            alu_op = ALU_PASS_MEM;
            alu_en = 1'b1;
          end
          ADD:
          begin
            alu_op = ALU_ADD;
            alu_en = 1'b1;
          end
          SUB:
          begin
            alu_op = ALU_SUB;
            alu_en = 1'b1;
          end
          AND:
          begin
            alu_op = ALU_AND;
            alu_en = 1'b1;
          end
          XOR:
          begin
            alu_op = ALU_XOR;
            alu_en = 1'b1;
          end
          ST:
          begin
            mem.addr = operand_addr;
            mem.wr   = 1'b1;
          end
          JMP:     pc_load = 1'b1;
          JZ:      pc_load = zero;
          HALT:    next_state = HALTED;
          default: ; // unused opcodes fall through as NOP
        endcase
      end
      default: next_state = IDLE;
    endcase
  end

endmodule

//--- hw/program_counter.sv
// program counter: instruction address that steps once per fetch
// and loads on start or on a taken jump
`timescale 1ns/10ps

module program_counter
#(
  parameter int addr_bits = 8
)
(
  input  logic                 CLK,
  input  logic                 rst_n,
  input  logic                 load,
  input  logic [addr_bits-1:0] load_value,
  input  logic                 step,
  output logic [addr_bits-1:0] pc
);

  logic [addr_bits-1:0] pc_q;

  always_ff @(posedge CLK or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pc_q <= '0;
    end
    else if (load) // a jump wins over the step of the same cycle
    begin
      pc_q <= load_value;
    end
    else if (step)
    begin
      pc_q <= pc_q + 1'b1; // wraps at the top of memory
    end
  end

  assign pc = pc_q;

endmodule

//--- hw/boot_memory.sv
// boot memory: single-port RAM shared by instructions and data
// holds a small summing program at power-up
`timescale 1ns/10ps

module boot_memory
  import cpu_pkg::*;
#(
  parameter int addr_bits = 8
)
(
  input logic      CLK,
  mem_bus_if.memory mem
);

  localparam int depth = 2 ** addr_bits;

  logic [data_w-1:0] ram [depth];

  initial
  begin
    for (int i = 0; i < depth; i++)
    begin
      ram[i] = '0;
    end

    // sums the three words at 0x10..0x12 and stores the result at 0x13
    ram[0] = {LDI, 12'h000};
    ram[1] = {ADD, 4'h0, 8'h10};
    ram[2] = {ADD, 4'h0, 8'h11};
    ram[3] = {ADD, 4'h0, 8'h12};
    ram[4] = {ST, 4'h0, 8'h13};
    ram[5] = {HALT, 12'h000};

    ram[16] = 16'h0003;
    ram[17] = 16'h0005;
    ram[18] = 16'h0007;
  end

  // a read in the cycle of a write still returns the old word
  always_ff @(posedge CLK)
  begin
    if (mem.wr)
    begin
      ram[mem.addr] <= mem.wdata;
    end
    mem.rdata <= ram[mem.addr];
  end

endmodule

//--- hw/mem_bus_if.sv
// memory bus between the sequencer and the boot memory
// one-cycle read latency, write on the edge where wr is high
`timescale 1ns/10ps

interface mem_bus_if
  import cpu_pkg::*;
#(
  parameter int addr_bits = 8
)
();

  logic [addr_bits-1:0] addr;
  logic [data_w-1:0]    wdata;
  logic [data_w-1:0]    rdata; // word at the address of the previous cycle
  logic                 wr;

  modport sequencer (
    output addr, wdata, wr,
    input  rdata
  );

  modport memory (
    input  addr, wdata, wr,
    output rdata
  );

endinterface

//--- hw/cpu_pkg.sv
// cpu package: widths, instruction formats, opcodes and FSM encodings
// shared by the 16-bit accumulator core
package cpu_pkg;

  localparam int data_w     = 16;
  localparam int addr_w_max = 12; // widest address a jump field can carry

  typedef enum logic [3:0] {
    NOP  = 4'h0,
    LDI  = 4'h1,
    LD   = 4'h2,
    ST   = 4'h3,
    ADD  = 4'h4,
    SUB  = 4'h5,
    AND  = 4'h6,
    XOR  = 4'h7,
    JMP  = 4'h8,
    JZ   = 4'h9,
    HALT = 4'hf
  } opcode_e;

  // immediate form, used by LDI, JMP and JZ
  typedef struct packed {
    opcode_e               opcode;
    logic [addr_w_max-1:0] imm;
  } imm_fmt_t;

  // direct form, the low byte addresses the operand word
  typedef struct packed {
    opcode_e    opcode;
    logic [3:0] rsvd;
    logic [7:0] addr;
  } mem_fmt_t;

  typedef union packed {
    imm_fmt_t imm_v;
    mem_fmt_t mem_v;
  } instr_t;

  typedef enum logic [2:0] {IDLE, FETCH, DECODE, OPREAD, EXEC, HALTED} seq_state_e;

  typedef enum logic [2:0] {
    ALU_PASS_IMM, ALU_PASS_MEM, ALU_ADD, ALU_SUB, ALU_AND, ALU_XOR, ALU_HOLD
  } alu_op_e;

endpackage
